//--- all.f
logic/rename_cfg_pkg.sv
logic/rename_types_pkg.sv
logic/rename_alloc_if.sv
logic/dest_alloc.sv
logic/src_lookup.sv
logic/rename_stage_reg.sv
logic/rename_top.sv
bench/rename_sva.sv
bench/rename_tb.sv

//--- bench/rename_sva.sv
`default_nettype none

module rename_sva (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         flush,
    input logic                         pause,
    input rename_types_pkg::pr_count_t  pr_num_need,
    input rename_types_pkg::pr_t        freelist_room,
    input rename_types_pkg::slot_mask_t alloc_en,
    input rename_types_pkg::slot_mask_t rat_wr_en,
    input rename_types_pkg::ar_t        dest_ar    [rename_cfg_pkg::slot_count],
    input rename_types_pkg::pr_t        dest_pr_s4 [rename_cfg_pkg::slot_count]
);

    timeunit 1ns;
    timeprecision 100ps;

    a_pause_room: assert property (@(posedge clk) disable iff (!rst_n)
        pause |-> (rename_types_pkg::pr_t'(pr_num_need) > freelist_room))
        else $error("pause raised while the free list has room");

    a_wr_needs_alloc: assert property (@(posedge clk) disable iff (!rst_n)
        (rat_wr_en & ~alloc_en) == '0)
        else $error("table write on a slot that does not allocate");

    for (genvar i = 0; i < rename_cfg_pkg::slot_count; i++) begin : g_slot
        a_flush_clear: assert property (@(posedge clk) disable iff (!rst_n)
            flush |=> (dest_pr_s4[i] == '0))
            else $error("destination PR survived a flush");

        for (genvar j = i + 1; j < rename_cfg_pkg::slot_count; j++) begin : g_pair
            a_one_writer: assert property (@(posedge clk) disable iff (!rst_n)
                !(rat_wr_en[i] && rat_wr_en[j] && (dest_ar[i] == dest_ar[j])))
                else $error("two table writes to the same AR");
        end
    end

endmodule

bind rename_top rename_sva u_sva (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush         (flush),
    .pause         (pause),
    .pr_num_need   (pr_num_need),
    .freelist_room (freelist_room),
    .alloc_en      (alloc_en),
    .rat_wr_en     (rat_wr_en),
    .dest_ar       (dest_ar),
    .dest_pr_s4    (dest_pr_s4)
);

`default_nettype wire

//--- bench/rename_tb.sv
`default_nettype none

module rename_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                         clk;
    logic                         rst_n;
    logic                         flush;
    logic                         hold;
    rename_types_pkg::slot_mask_t slot_vld;
    rename_types_pkg::slot_mask_t dest_vld;
    logic [rename_cfg_pkg::slot_count-1:0][rename_cfg_pkg::src_count-1:0] src_vld;
    rename_types_pkg::ar_t        dest_ar [rename_cfg_pkg::slot_count];
    rename_types_pkg::ar_t        src_ar  [rename_cfg_pkg::slot_count][rename_cfg_pkg::src_count];
    rename_types_pkg::pr_t        rd_ptr;
    rename_types_pkg::pr_t        freelist_room;
    rename_types_pkg::ar_mask_t   rat_valid;
    rename_types_pkg::pr_t        rat_map [rename_cfg_pkg::ar_count];

    rename_types_pkg::slot_mask_t alloc_en;
    rename_types_pkg::pr_t        new_pr [rename_cfg_pkg::slot_count];
    rename_types_pkg::pr_count_t  pr_num_need;
    logic                         pause;
    rename_types_pkg::slot_mask_t rat_wr_en;
    rename_types_pkg::pr_t        dest_pr_s4 [rename_cfg_pkg::slot_count];
    rename_types_pkg::pr_t        src_pr_s4  [rename_cfg_pkg::slot_count][rename_cfg_pkg::src_count];

    rename_types_pkg::slot_mask_t exp_alloc_en;
    rename_types_pkg::pr_t        exp_new_pr [rename_cfg_pkg::slot_count];
    rename_types_pkg::pr_count_t  exp_need;
    logic                         exp_pause;
    rename_types_pkg::slot_mask_t exp_wr_en;
    rename_types_pkg::pr_t        exp_src_pr [rename_cfg_pkg::slot_count][rename_cfg_pkg::src_count];
    rename_types_pkg::pr_t        exp_dest_s4 [rename_cfg_pkg::slot_count];
    rename_types_pkg::pr_t        exp_src_s4  [rename_cfg_pkg::slot_count][rename_cfg_pkg::src_count];

    int cycle_cnt = 0;
    int err_cnt   = 0;

    rename_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .hold          (hold),
        .slot_vld      (slot_vld),
        .dest_vld      (dest_vld),
        .src_vld       (src_vld),
        .dest_ar       (dest_ar),
        .src_ar        (src_ar),
        .rd_ptr        (rd_ptr),
        .freelist_room (freelist_room),
        .rat_valid     (rat_valid),
        .rat_map       (rat_map),
        .alloc_en      (alloc_en),
        .new_pr        (new_pr),
        .pr_num_need   (pr_num_need),
        .pause         (pause),
        .rat_wr_en     (rat_wr_en),
        .dest_pr_s4    (dest_pr_s4),
        .src_pr_s4     (src_pr_s4)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;                           // 4 ns period

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic check_value(input string test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            err_cnt++;
            $display("error: %s %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // polls at half-ns points so it never lands on a clock edge
    task automatic wait_edges(input int n);
        int target;
        int polls;
        target = cycle_cnt + n;
        polls  = 0;
        while (cycle_cnt < target) begin
            #1;
            polls++;
            if (polls > 4 * n + 8) begin
                $display("error: no rising clock edge seen within %0d ns", polls);
                $display("TEST FAIL");
                $fatal(1, "clock timeout");
            end
        end
        #0.5;                                       // one ns after the edge
    endtask

    task automatic clear_inputs();
        rst_n         = 1'b0;
        flush         = 1'b0;
        hold          = 1'b0;
        slot_vld      = '0;
        dest_vld      = '0;
        src_vld       = '0;
        rd_ptr        = '0;
        freelist_room = '0;
        rat_valid     = '0;
        for (int i = 0; i < rename_cfg_pkg::slot_count; i++) begin
            dest_ar[i]     = '0;
            exp_dest_s4[i] = '0;
            for (int s = 0; s < rename_cfg_pkg::src_count; s++) begin
                src_ar[i][s]     = '0;
                exp_src_s4[i][s] = '0;
            end
        end
        for (int a = 0; a < rename_cfg_pkg::ar_count; a++) begin
            rat_map[a] = '0;
        end
    endtask

    task automatic randomize_rat();
        rat_valid = rename_types_pkg::ar_mask_t'($urandom);
        for (int a = 0; a < rename_cfg_pkg::ar_count; a++) begin
            rat_map[a] = rename_types_pkg::pr_t'($urandom);
        end
    endtask

    // small ar_span forces repeated ARs inside a group
    task automatic randomize_group(input int ar_span);
        for (int i = 0; i < rename_cfg_pkg::slot_count; i++) begin
            slot_vld[i] = ($urandom % 8) != 0;
            dest_vld[i] = ($urandom % 4) != 0;
            dest_ar[i]  = rename_types_pkg::ar_t'($urandom % ar_span);
            if (($urandom % 6) == 0) begin
                dest_ar[i] = '0;                    // zero AR never renamed
            end
            for (int s = 0; s < rename_cfg_pkg::src_count; s++) begin
                src_vld[i][s] = ($urandom % 4) != 0;
                src_ar[i][s]  = rename_types_pkg::ar_t'($urandom % ar_span);
            end
        end
        rd_ptr        = rename_types_pkg::pr_t'($urandom);
        freelist_room = rename_types_pkg::pr_t'($urandom % 6);
    endtask

    task automatic model_comb();
        rename_types_pkg::pr_t      cnt;
        rename_types_pkg::ar_mask_t seen;
        rename_types_pkg::ar_t      ar;
        logic                       found;
        cnt = '0;
        for (int i = 0; i < rename_cfg_pkg::slot_count; i++) begin
            exp_alloc_en[i] = slot_vld[i] && dest_vld[i] && (dest_ar[i] != '0);
            exp_new_pr[i]   = '0;
            if (exp_alloc_en[i]) begin
                exp_new_pr[i] = (rd_ptr & 7'h3f) + cnt + 7'd1;
                cnt           = cnt + 7'd1;
            end
        end
        exp_need  = (!flush && !hold) ? rename_types_pkg::pr_count_t'(cnt) : '0;
        exp_pause = rename_types_pkg::pr_t'(exp_need) > freelist_room;

        // walk from the youngest slot so the first sighting is the last writer
        seen = '0;
        for (int i = rename_cfg_pkg::slot_count - 1; i >= 0; i--) begin
            exp_wr_en[i] = exp_alloc_en[i] && !seen[dest_ar[i]];
            if (exp_alloc_en[i]) begin
                seen[dest_ar[i]] = 1'b1;
            end
        end

        for (int i = 0; i < rename_cfg_pkg::slot_count; i++) begin
            for (int s = 0; s < rename_cfg_pkg::src_count; s++) begin
                ar               = src_ar[i][s];
                exp_src_pr[i][s] = rat_valid[ar] ? rat_map[ar] : '0;
                found            = 1'b0;
                for (int j = i - 1; j >= 0; j--) begin
                    if (!found && exp_alloc_en[j] && (dest_ar[j] == ar)) begin
                        exp_src_pr[i][s] = exp_new_pr[j];
                        found            = 1'b1;
                    end
                end
            end
        end
    endtask

    task automatic model_edge();
        for (int i = 0; i < rename_cfg_pkg::slot_count; i++) begin
            if (flush) begin
                exp_dest_s4[i] = '0;
            end else if (!hold) begin
                exp_dest_s4[i] = exp_new_pr[i];
            end
            for (int s = 0; s < rename_cfg_pkg::src_count; s++) begin
                if (flush) begin
                    exp_src_s4[i][s] = '0;
                end else if (!hold && slot_vld[i] && src_vld[i][s]) begin
                    exp_src_s4[i][s] = exp_src_pr[i][s];
                end
            end
        end
    endtask

    task automatic check_regs(input string name);
        for (int i = 0; i < rename_cfg_pkg::slot_count; i++) begin
            check_value(name, "dest_pr_s4", 32'(exp_dest_s4[i]), 32'(dest_pr_s4[i]));
            for (int s = 0; s < rename_cfg_pkg::src_count; s++) begin
                check_value(name, "src_pr_s4", 32'(exp_src_s4[i][s]), 32'(src_pr_s4[i][s]));
            end
        end
    endtask

    task automatic settle_and_check(input string name);
        #0.5;
        model_comb();
        check_value(name, "alloc_en", 32'(exp_alloc_en), 32'(alloc_en));
        for (int i = 0; i < rename_cfg_pkg::slot_count; i++) begin
            check_value(name, "new_pr", 32'(exp_new_pr[i]), 32'(new_pr[i]));
        end
        check_value(name, "pr_num_need", 32'(exp_need), 32'(pr_num_need));
        check_value(name, "pause", 32'(exp_pause), 32'(pause));
        check_value(name, "rat_wr_en", 32'(exp_wr_en), 32'(rat_wr_en));
    endtask

    task automatic finish_cycle(input string name);
        model_edge();
        wait_edges(1);
        check_regs(name);
    endtask

    task automatic run_cycle(input string name);
        settle_and_check(name);
        finish_cycle(name);
    endtask

    task automatic test_reset();
        #1.5;
        wait_edges(8);
        check_regs("reset");
        rst_n = 1'b1;
        for (int n = 0; n < 4; n++) begin
            run_cycle("reset_idle");                // all slots invalid
        end
    endtask

    task automatic test_random_alloc();
        for (int n = 0; n < 200; n++) begin
            if ((n % 16) == 0) begin
                randomize_rat();
            end
            randomize_group(rename_cfg_pkg::ar_count);
            run_cycle("random_alloc");
        end
    endtask

    task automatic test_src_lookup();
        for (int n = 0; n < 150; n++) begin
            randomize_rat();
            randomize_group(4);
            run_cycle("src_lookup");
        end
    endtask

    task automatic drive_writers(input string name, input int a0, input int a1,
                                 input int a2, input int a3,
                                 input logic [3:0] sv, input logic [3:0] dv,
                                 input logic [3:0] exp_mask);
        randomize_group(10);
        slot_vld   = sv;
        dest_vld   = dv;
        src_vld    = '1;
        dest_ar[0] = rename_types_pkg::ar_t'(a0);
        dest_ar[1] = rename_types_pkg::ar_t'(a1);
        dest_ar[2] = rename_types_pkg::ar_t'(a2);
        dest_ar[3] = rename_types_pkg::ar_t'(a3);
        settle_and_check(name);
        check_value(name, "rat_wr_en literal", 32'(exp_mask), 32'(rat_wr_en));
        finish_cycle(name);
    endtask

    task automatic test_last_writer();
        randomize_rat();
        drive_writers("last_writer_all", 5, 5, 5, 5, 4'b1111, 4'b1111, 4'b1000);
        drive_writers("last_writer_pairs", 7, 9, 7, 9, 4'b1111, 4'b1111, 4'b1100);
        drive_writers("last_writer_no_dest", 5, 5, 5, 5, 4'b1111, 4'b0111, 4'b0100);
        drive_writers("last_writer_zero_ar", 3, 3, 0, 0, 4'b1111, 4'b1111, 4'b0010);
        drive_writers("last_writer_gaps", 6, 6, 6, 6, 4'b0101, 4'b1111, 4'b0100);
    endtask

    task automatic test_hold_flush();
        randomize_rat();
        randomize_group(8);
        run_cycle("hold_flush_load");
        hold = 1'b1;
        for (int n = 0; n < 3; n++) begin
            randomize_group(8);
            settle_and_check("hold_freeze");
            check_value("hold_freeze", "pr_num_need", 32'd0, 32'(pr_num_need));
            finish_cycle("hold_freeze");
        end
        hold  = 1'b0;
        flush = 1'b1;
        randomize_group(8);
        run_cycle("flush_clear");
        for (int i = 0; i < rename_cfg_pkg::slot_count; i++) begin
            check_value("flush_clear", "dest_pr_s4", 32'd0, 32'(dest_pr_s4[i]));
        end
        for (int n = 0; n < 80; n++) begin
            randomize_group(8);
            hold  = ($urandom % 5) == 0;
            flush = ($urandom % 7) == 0;
            run_cycle("hold_flush_mix");
        end
        hold  = 1'b0;
        flush = 1'b0;
    endtask

    // reset while the registers hold nonzero values
    task automatic test_async_reset();
        randomize_rat();
        randomize_group(8);
        slot_vld = '1;
        dest_vld = '1;
        src_vld  = '1;
        for (int i = 0; i < rename_cfg_pkg::slot_count; i++) begin
            dest_ar[i] = rename_types_pkg::ar_t'(i + 1);
        end
        run_cycle("reset_load");
        rst_n = 1'b0;
        for (int i = 0; i < rename_cfg_pkg::slot_count; i++) begin
            exp_dest_s4[i] = '0;
            for (int s = 0; s < rename_cfg_pkg::src_count; s++) begin
                exp_src_s4[i][s] = '0;
            end
        end
        #0.5;
        check_regs("reset_async");                  // cleared before the next edge
        wait_edges(2);
        check_regs("reset_async");
        rst_n = 1'b1;
        run_cycle("reset_release");
    endtask

    initial begin
        void'($urandom(50206));
        clear_inputs();
        test_reset();
        test_random_alloc();
        test_src_lookup();
        test_last_writer();
        test_hold_flush();
        test_async_reset();
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/dest_alloc.sv
`default_nettype none

module dest_alloc (
    input  rename_types_pkg::slot_mask_t slot_vld,
    input  rename_types_pkg::slot_mask_t dest_vld,
    input  rename_types_pkg::ar_t        dest_ar_in [rename_cfg_pkg::slot_count],
    input  rename_types_pkg::pr_t        rd_ptr,
    input  rename_types_pkg::pr_t        freelist_room,

    rename_alloc_if.alloc_mp             alloc,

    output rename_types_pkg::pr_count_t  pr_num_need,
    output logic                         pause,
    output rename_types_pkg::slot_mask_t rat_wr_en
);

    rename_types_pkg::slot_mask_t alloc_en;
    rename_types_pkg::pr_t        new_pr [rename_cfg_pkg::slot_count];
    rename_types_pkg::pr_t        pr_base;
    rename_types_pkg::pr_count_t  alloc_num;

    // low pointer bits, zero-extended
    assign pr_base = rename_types_pkg::pr_t'(rd_ptr[rename_cfg_pkg::ptr_idx_width-1:0]);

    always_comb begin
        for (int i = 0; i < rename_cfg_pkg::slot_count; i++) begin
            alloc_en[i] = slot_vld[i] && dest_vld[i] &&
                          (dest_ar_in[i] != rename_types_pkg::ar_t'(rename_cfg_pkg::zero_ar));
        end
    end

    // prefix count gives consecutive PRs to allocating slots only
    always_comb begin
        rename_types_pkg::pr_count_t cnt;
        cnt = '0;
        for (int i = 0; i < rename_cfg_pkg::slot_count; i++) begin
            if (alloc_en[i]) begin
                new_pr[i] = pr_base + rename_types_pkg::pr_t'(cnt) + rename_types_pkg::pr_t'(1);
                cnt       = cnt + rename_types_pkg::pr_count_t'(1);
            end else begin
                new_pr[i] = '0;
            end
        end
        alloc_num = cnt;
    end

    assign pr_num_need = alloc.advance ? alloc_num : '0;   // nothing requested while stalled
    assign pause       = rename_types_pkg::pr_t'(pr_num_need) > freelist_room;

    // last writer of each AR in the group owns the table update
    always_comb begin
        for (int i = 0; i < rename_cfg_pkg::slot_count; i++) begin
            rat_wr_en[i] = alloc_en[i];
            for (int j = i + 1; j < rename_cfg_pkg::slot_count; j++) begin
                if (alloc_en[j] && (dest_ar_in[j] == dest_ar_in[i])) begin
                    rat_wr_en[i] = 1'b0;                    // younger slot overwrites
                end
            end
        end
    end

    assign alloc.alloc_en = alloc_en;
    assign alloc.dest_ar  = dest_ar_in;
    assign alloc.new_pr   = new_pr;

endmodule

`default_nettype wire

//--- logic/rename_alloc_if.sv
`default_nettype none

// per-slot allocation results shared inside the rename stage
interface rename_alloc_if;

    rename_types_pkg::slot_mask_t alloc_en;                                  // slot gets a new PR
    rename_types_pkg::ar_t dest_ar [$bits(rename_types_pkg::slot_mask_t)];
    rename_types_pkg::pr_t new_pr  [$bits(rename_types_pkg::slot_mask_t)];  // zero if no alloc
    logic                  advance;                                          // stage moves on

    modport alloc_mp (
        output alloc_en,
        output dest_ar,
        output new_pr,
        input  advance
    );

    modport lookup_mp (
        input  alloc_en,
        input  dest_ar,
        input  new_pr
    );

    modport stage_mp (
        input  new_pr,
        output advance
    );

endinterface

`default_nettype wire

//--- logic/rename_cfg_pkg.sv
`default_nettype none

// sizing of the four-wide rename stage
package rename_cfg_pkg;

    // group shape
    localparam int slot_count = 4;           // instructions per group
    localparam int src_count  = 2;           // source operands per instruction

    // architectural side
    localparam int ar_width   = 5;
    localparam int ar_count   = 32;
    localparam int zero_ar    = 0;           // hardwired zero, never renamed

    // physical side
    localparam int pr_width      = 7;
    localparam int ptr_idx_width = 6;        // rd_ptr bits used as allocation base

endpackage

`default_nettype wire

//--- logic/rename_stage_reg.sv
`default_nettype none

module rename_stage_reg (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush,
    input  logic                         hold,

    input  rename_types_pkg::slot_mask_t slot_vld,
    input  logic [rename_cfg_pkg::slot_count-1:0][rename_cfg_pkg::src_count-1:0] src_vld,
    input  rename_types_pkg::pr_t        src_pr_next [rename_cfg_pkg::slot_count]
                                                     [rename_cfg_pkg::src_count],

    rename_alloc_if.stage_mp             alloc,

    output rename_types_pkg::pr_t        dest_pr_s4 [rename_cfg_pkg::slot_count],
    output rename_types_pkg::pr_t        src_pr_s4  [rename_cfg_pkg::slot_count]
                                                    [rename_cfg_pkg::src_count]
);

    assign alloc.advance = !flush && !hold;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dest_pr_s4 <= '{default: '0};
        end else if (flush) begin
            dest_pr_s4 <= '{default: '0};
        end else if (alloc.advance) begin
            dest_pr_s4 <= alloc.new_pr;                 // zero for non-allocating slots
        end
    end

    // source entries keep their old value unless slot and operand are valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_pr_s4 <= '{default: '0};
        end else if (flush) begin
            src_pr_s4 <= '{default: '0};
        end else if (alloc.advance) begin
            for (int i = 0; i < rename_cfg_pkg::slot_count; i++) begin
                for (int s = 0; s < rename_cfg_pkg::src_count; s++) begin
                    if (slot_vld[i] && src_vld[i][s]) begin
                        src_pr_s4[i][s] <= src_pr_next[i][s];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/rename_top.sv
`default_nettype none

module rename_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush,
    input  logic                         hold,

    input  rename_types_pkg::slot_mask_t slot_vld,
    input  rename_types_pkg::slot_mask_t dest_vld,
    input  logic [rename_cfg_pkg::slot_count-1:0][rename_cfg_pkg::src_count-1:0] src_vld,
    input  rename_types_pkg::ar_t        dest_ar [rename_cfg_pkg::slot_count],
    input  rename_types_pkg::ar_t        src_ar  [rename_cfg_pkg::slot_count]
                                                 [rename_cfg_pkg::src_count],

    input  rename_types_pkg::pr_t        rd_ptr,
    input  rename_types_pkg::pr_t        freelist_room,

    input  rename_types_pkg::ar_mask_t   rat_valid,
    input  rename_types_pkg::pr_t        rat_map [rename_cfg_pkg::ar_count],

    output rename_types_pkg::slot_mask_t alloc_en,
    output rename_types_pkg::pr_t        new_pr [rename_cfg_pkg::slot_count],
    output rename_types_pkg::pr_count_t  pr_num_need,
    output logic                         pause,
    output rename_types_pkg::slot_mask_t rat_wr_en,

    output rename_types_pkg::pr_t        dest_pr_s4 [rename_cfg_pkg::slot_count],
    output rename_types_pkg::pr_t        src_pr_s4  [rename_cfg_pkg::slot_count]
                                                    [rename_cfg_pkg::src_count]
);

    rename_types_pkg::pr_t src_pr_next [rename_cfg_pkg::slot_count][rename_cfg_pkg::src_count];

    rename_alloc_if alloc_bus ();

    dest_alloc u_dest_alloc (
        .slot_vld      (slot_vld),
        .dest_vld      (dest_vld),
        .dest_ar_in    (dest_ar),
        .rd_ptr        (rd_ptr),
        .freelist_room (freelist_room),
        .alloc         (alloc_bus.alloc_mp),
        .pr_num_need   (pr_num_need),
        .pause         (pause),
        .rat_wr_en     (rat_wr_en)
    );

    src_lookup u_src_lookup (
        .slot_vld    (slot_vld),
        .src_ar      (src_ar),
        .rat_valid   (rat_valid),
        .rat_map     (rat_map),
        .alloc       (alloc_bus.lookup_mp),
        .src_pr_next (src_pr_next)
    );

    rename_stage_reg u_stage_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .hold        (hold),
        .slot_vld    (slot_vld),
        .src_vld     (src_vld),
        .src_pr_next (src_pr_next),
        .alloc       (alloc_bus.stage_mp),
        .dest_pr_s4  (dest_pr_s4),
        .src_pr_s4   (src_pr_s4)
    );

    // same-cycle allocation results go straight out
    assign alloc_en = alloc_bus.alloc_en;
    assign new_pr   = alloc_bus.new_pr;

endmodule

`default_nettype wire

//--- logic/rename_types_pkg.sv
`default_nettype none

package rename_types_pkg;

    typedef logic [rename_cfg_pkg::ar_width-1:0] ar_t;        // architectural reg number
    typedef logic [rename_cfg_pkg::pr_width-1:0] pr_t;        // physical reg, pointer, room

    typedef logic [rename_cfg_pkg::slot_count-1:0] slot_mask_t;

    // 0 .. slot_count PRs per group
    typedef logic [$clog2(rename_cfg_pkg::slot_count + 1)-1:0] pr_count_t;

    typedef logic [rename_cfg_pkg::ar_count-1:0] ar_mask_t;   // one bit per AR

endpackage

`default_nettype wire

//--- logic/src_lookup.sv
`default_nettype none

module src_lookup (
    input  rename_types_pkg::slot_mask_t slot_vld,
    input  rename_types_pkg::ar_t        src_ar [rename_cfg_pkg::slot_count]
                                                [rename_cfg_pkg::src_count],
    input  rename_types_pkg::ar_mask_t   rat_valid,
    input  rename_types_pkg::pr_t        rat_map [rename_cfg_pkg::ar_count],

    rename_alloc_if.lookup_mp            alloc,

    output rename_types_pkg::pr_t        src_pr_next [rename_cfg_pkg::slot_count]
                                                     [rename_cfg_pkg::src_count]
);

    always_comb begin
        for (int i = 0; i < rename_cfg_pkg::slot_count; i++) begin
            for (int s = 0; s < rename_cfg_pkg::src_count; s++) begin
                // table first, bypass overrides it below
                if (rat_valid[src_ar[i][s]]) begin
                    src_pr_next[i][s] = rat_map[src_ar[i][s]];
                end else begin
                    src_pr_next[i][s] = '0;             // unmapped AR
                end

                // scan older slots in order so the youngest match is last
                for (int j = 0; j < i; j++) begin
                    if (alloc.alloc_en[j] && (alloc.dest_ar[j] == src_ar[i][s])) begin
                        src_pr_next[i][s] = alloc.new_pr[j];
                    end
                end

                if (!slot_vld[i]) begin
                    src_pr_next[i][s] = '0;             // empty slot
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build the rename stage testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/100ps --top-module rename_tb -f all.f -o rename_sim &&
./obj_dir/rename_sim | tee /dev/stderr | grep "TEST PASS" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
